// ==== Makefile ====
# Verilator flow for the acoustic rangefinder
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= sos_ranger_tb
RTL_TOP    ?= sos_ranger_top
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
FAIL_MSG   ?= Test FAILED
PASS_MSG   ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
source/sos_pkg.sv
source/sample_strobe_gen.sv
source/impulse_generator.sv
source/window_energy.sv
source/sos_dist_calculator.sv
source/sos_ranger_top.sv
sim/sos_ranger_tb.sv

// ==== sim/sos_ranger_tb.sv ====
`default_nettype none

module sos_ranger_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_div     = 4;
  localparam int window_size = 16;
  localparam int max_delay   = 256;
  localparam int click_len   = 8;
  localparam int delay_w     = $clog2(max_delay + 1);
  localparam int echo_runs   = 20;
  localparam int n_runs      = echo_runs + 3; // plus click, timeout and busy trigger runs
  // each run is at worst a whole click plus a whole listen
  localparam int cycle_limit = (click_len + max_delay + 4) * clk_div * n_runs
                             + 50 * n_runs + 100;

  logic                                 clk_in;
  logic                                 rst_in;
  logic                                 trigger;
  logic signed [sos_pkg::sample_w-1:0]  mic_in;
  logic signed [sos_pkg::amp_w-1:0]     amp_out;
  logic                                 sample_strobe;
  logic [delay_w-1:0]                   delay;
  logic                                 delay_valid;
  sos_pkg::ranger_state_t               current_state;

  // microphone record for one listening phase with one entry per strobe
  logic signed [sos_pkg::sample_w-1:0]  listen_samples [0:max_delay+1];
  logic signed [sos_pkg::amp_w-1:0]     click_vals [$]; // nonzero amp_out seen while emitting

  int listen_pos;   // strobes seen while listening
  int stray_amp;    // nonzero speaker samples while listening
  int last_strobe;  // cycle of the previous sample strobe
  bit start_req;
  bit poke_busy;    // throw extra triggers at a busy DUT
  int cycle_count = 0;
  int check_errors;
  int tests_run;
  int tests_failed;

  sos_ranger_top #(
    .clk_div     (clk_div),
    .window_size (window_size),
    .max_delay   (max_delay),
    .click_len   (click_len)
  ) sos_ranger_top_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .trigger       (trigger),
    .mic_in        (mic_in),
    .amp_out       (amp_out),
    .sample_strobe (sample_strobe),
    .delay         (delay),
    .delay_valid   (delay_valid),
    .current_state (current_state)
  );

  initial begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT did not finish its measurements",
               cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // background noise uniform in -3..3
  function automatic logic signed [sos_pkg::sample_w-1:0] noise_sample();
    int v;
    v = int'($urandom_range(6, 0)) - 3;
    return sos_pkg::sample_w'(v);
  endfunction

  // loud echo from start to the end of the record with a random sign per sample
  function automatic void add_burst(input int start);
    int mag;
    for (int k = start; k <= max_delay + 1; k++) begin
      mag = int'($urandom_range(120, 60));
      if ($urandom_range(1, 0) == 1) begin
        mag = -mag;
      end
      listen_samples[k] = sos_pkg::sample_w'(mag);
    end
  endfunction

  // reference model of the onset test over window sums of |sample|
  // 0 means no echo before the limit
  function automatic int predict_delay();
    longint prev;
    longint older;
    longint sum;
    int     s;
    prev  = 64'h0000_0000_FFFF_FFFF; // history starts saturated
    older = 64'h0000_0000_FFFF_FFFF;
    for (int w = 0; w < max_delay / window_size; w++) begin
      sum = 0;
      for (int i = 0; i < window_size; i++) begin
        s = listen_samples[w * window_size + i];
        sum += (s < 0) ? -s : s;
      end
      if (sum > prev && sum > older + older / 2) begin
        return (w + 1) * window_size;
      end
      older = prev;
      prev  = sum;
    end
    return 0;
  endfunction

  task automatic compare_value(input string test, input string what,
                               input longint expected, input longint actual);
    assert (expected == actual) else begin
      $display("Error: %s %s expected %0d actual %0d", test, what, expected, actual);
      check_errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (check_errors == errs_before) begin
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d wrong", name, check_errors - errs_before);
    end
  endtask

  // noise record that on its own never looks like an echo
  task automatic fill_quiet_noise();
    int tries;
    tries = 0;
    do begin
      foreach (listen_samples[k])
        listen_samples[k] = noise_sample();
      tries++;
    end while (predict_delay() != 0 && tries < 50);
    assert (predict_delay() == 0) else begin
      $display("could not draw a noise record free of false echoes");
      check_errors++;
    end
  endtask

  task automatic prepare_echo(output int exp_delay);
    int start;
    fill_quiet_noise();
    start = int'($urandom_range(max_delay - window_size - 1, 2 * window_size));
    add_burst(start);
    exp_delay = predict_delay();
  endtask

  // one clock with outputs read and inputs changed 1 ns after the edge
  task automatic tick();
    @(posedge clk_in);
    #1;
    if (sample_strobe) begin
      if (last_strobe >= 0) begin
        compare_value("sample_strobe", "strobe period", clk_div, cycle_count - last_strobe);
      end
      last_strobe = cycle_count;
      if (current_state == sos_pkg::emitting && amp_out != 0) begin
        click_vals.push_back(amp_out);
      end
      if (current_state == sos_pkg::listening && amp_out != 0) begin
        stray_amp++;
      end
      // this sample is taken by the DUT at the end of the strobe cycle
      if (current_state == sos_pkg::listening && listen_pos <= max_delay + 1) begin
        mic_in = listen_samples[listen_pos];
        listen_pos++;
      end else begin
        mic_in = noise_sample();
      end
    end
    trigger = (start_req && current_state == sos_pkg::idle)
           || (poke_busy && current_state != sos_pkg::idle && $urandom_range(1, 0) == 1);
  endtask

  task automatic check_reset();
    int errs_before;
    errs_before = check_errors;
    compare_value("reset", "delay_valid", 0, delay_valid);
    compare_value("reset", "delay", 0, delay);
    compare_value("reset", "amp_out", 0, amp_out);
    compare_value("reset", "sample_strobe", 0, sample_strobe);
    compare_value("reset", "current_state", sos_pkg::idle, current_state);
    finish_test("reset", errs_before);
  endtask

  // exp_delay of 0 expects a timeout
  task automatic run_measurement(input string name, input int exp_delay, input bit pokes);
    int errs_before;
    errs_before = check_errors;
    click_vals.delete();
    stray_amp  = 0;
    listen_pos = 0;
    poke_busy  = pokes;
    start_req  = 1'b1;
    trigger    = 1'b1;
    do begin
      tick();
    end while (current_state == sos_pkg::idle);
    start_req = 1'b0;
    while (current_state != sos_pkg::idle) begin
      tick();
    end
    poke_busy = 1'b0;

    compare_value(name, "click length", click_len, click_vals.size());
    foreach (click_vals[k]) begin
      compare_value(name, $sformatf("click sample %0d", k),
                    (k % 2 == 0) ? sos_pkg::click_amp : -sos_pkg::click_amp,
                    click_vals[k]);
    end
    assert (stray_amp == 0) else begin
      $display("%s: speaker output moved while listening, the click restarted", name);
      check_errors++;
    end

    if (exp_delay != 0) begin
      compare_value(name, "delay_valid", 1, delay_valid);
      compare_value(name, "delay", exp_delay, delay);
    end else begin
      compare_value(name, "delay_valid", 0, delay_valid);
      assert (listen_pos >= max_delay && listen_pos <= max_delay + 1) else begin
        $display("%s: listening ended after %0d samples instead of %0d",
                 name, listen_pos, max_delay);
        check_errors++;
      end
    end
    repeat (3) tick();
    finish_test(name, errs_before);
  endtask

  initial begin
    int exp_delay;
    void'($urandom(33));
    rst_in       = 1'b1;
    trigger      = 1'b0;
    mic_in       = '0;
    start_req    = 1'b0;
    poke_busy    = 1'b0;
    listen_pos   = 0;
    stray_amp    = 0;
    last_strobe  = -1;
    check_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    check_reset();

    prepare_echo(exp_delay);
    run_measurement("click", exp_delay, 1'b0);

    for (int r = 0; r < echo_runs; r++) begin
      prepare_echo(exp_delay);
      run_measurement($sformatf("echo_%02d", r), exp_delay, 1'b0);
    end

    fill_quiet_noise(); // the model expects no echo from noise alone
    run_measurement("timeout", predict_delay(), 1'b0);

    prepare_echo(exp_delay);
    run_measurement("busy_trigger", exp_delay, 1'b1);

    $display("tests %0d, passed %0d, failed %0d, wrong checks %0d",
             tests_run, tests_run - tests_failed, tests_failed, check_errors);
    if (check_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/impulse_generator.sv ====
`default_nettype none

module impulse_generator #(
  parameter int click_len = 8 // samples in the click
) (
  input  wire                                   clk_in,
  input  wire                                   rst_in,
  input  wire                                   step,
  input  wire                                   fire,
  output logic signed [sos_pkg::amp_w-1:0]      amp_out,
  output logic                                  done
);

  localparam int cnt_w = $clog2(click_len + 1);

  logic             busy;
  logic [cnt_w-1:0] cnt; // click samples already played
  logic             neg; // sign of the next click sample

  // the click is a square burst: +peak, -peak, +peak ... one value per sample.
  // each value holds for a full sample period, so the burst is over on the
  // step after the last one; that step zeroes the output and reports done
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy    <= 1'b0;
      cnt     <= '0;
      neg     <= 1'b0;
      amp_out <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (fire) begin // fire while busy falls through and is dropped
          busy <= 1'b1;
          cnt  <= '0;
          neg  <= 1'b0; // first half-cycle is positive
        end
      end else if (step) begin
        if (cnt == cnt_w'(click_len)) begin
          amp_out <= '0;
          busy    <= 1'b0;
          done    <= 1'b1;
        end else begin
          amp_out <= neg ? -sos_pkg::click_amp : sos_pkg::click_amp;
          neg     <= ~neg;
          cnt     <= cnt + 1'b1;
        end
      end
    end
  end

  // fire only comes from an idle controller, done only while it emits
  a_fire_done_apart : assert property (
    @(posedge clk_in) disable iff (rst_in)
    !(done && fire)
  ) else $error("click done coincides with a new fire");

endmodule

`default_nettype wire

// ==== source/sample_strobe_gen.sv ====
`default_nettype none

module sample_strobe_gen #(
  parameter int clk_div = 4 // system clocks per audio sample
) (
  input  wire  clk_in,
  input  wire  rst_in,
  output logic step
);

  localparam int cnt_w = (clk_div > 1) ? $clog2(clk_div) : 1;

  logic [cnt_w-1:0] cnt;

  // wrapping divider, step is high for the single cycle where the count wraps
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cnt  <= '0;
      step <= 1'b0;
    end else if (cnt == cnt_w'(clk_div - 1)) begin
      cnt  <= '0;
      step <= 1'b1;
    end else begin
      cnt  <= cnt + 1'b1;
      step <= 1'b0;
    end
  end

  // with any real division the strobe must drop again straight away
  a_step_single : assert property (
    @(posedge clk_in) disable iff (rst_in)
    (clk_div > 1) && step |=> !step
  ) else $error("sample strobe held high for two cycles");

endmodule

`default_nettype wire

// ==== source/sos_dist_calculator.sv ====
`default_nettype none

module sos_dist_calculator #(
  parameter int max_delay   = 256, // samples to listen before giving up
  parameter int window_size = 16,
  parameter int click_len   = 8
) (
  input  wire                                     clk_in,
  input  wire                                     rst_in,
  input  wire                                     step,
  input  wire                                     trigger,
  input  wire [sos_pkg::energy_w-1:0]             window_sum,
  input  wire                                     window_done,
  output logic                                    clear,
  output logic signed [sos_pkg::amp_w-1:0]        amp_out,
  output logic [$clog2(max_delay + 1)-1:0]        delay,      // in samples
  output logic                                    delay_valid,
  output sos_pkg::ranger_state_t                  current_state
);

  localparam int delay_w = $clog2(max_delay + 1);

  sos_pkg::ranger_state_t         state;
  logic                           fire; // one-cycle start of the click
  logic                           done; // one-cycle end of the click
  logic [delay_w-1:0]             step_cnt; // samples since listening began
  logic [sos_pkg::energy_w-1:0]   prev_sum;
  logic [sos_pkg::energy_w-1:0]   prev_prev_sum;
  logic [sos_pkg::energy_w:0]     threshold; // one extra bit so 1.5x never wraps
  logic                           echo;

  impulse_generator #(
    .click_len (click_len)
  ) impulse_generator_i (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .step    (step),
    .fire    (fire),
    .amp_out (amp_out),
    .done    (done)
  );

  assign current_state = state;

  // restart the window accumulator in the same cycle the click ends, so its
  // windows line up with step_cnt
  assign clear = done && (state == sos_pkg::emitting);

  // onset when louder than the last window and above 1.5x the one before it
  assign threshold = {1'b0, prev_prev_sum}
                   + {2'b00, prev_prev_sum[sos_pkg::energy_w-1:1]};
  assign echo = (window_sum > prev_sum) && ({1'b0, window_sum} > threshold);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state       <= sos_pkg::idle;
      fire        <= 1'b0;
      step_cnt    <= '0;
      delay       <= '0;
      delay_valid <= 1'b0;
    end else begin
      fire <= 1'b0;
      case (state)
        sos_pkg::idle: begin
          if (trigger) begin
            fire        <= 1'b1;
            delay_valid <= 1'b0; // old result is dropped on a new measurement
            state       <= sos_pkg::emitting;
          end
        end

        sos_pkg::emitting: begin
          if (done) begin
            step_cnt <= '0;
            state    <= sos_pkg::listening;
          end
        end

        sos_pkg::listening: begin
          if (window_done && echo) begin
            delay       <= step_cnt; // always a whole number of windows
            delay_valid <= 1'b1;
            state       <= sos_pkg::idle;
          end else if (step && (step_cnt == delay_w'(max_delay))) begin
            state <= sos_pkg::idle; // no echo heard before the limit
          end else if (step) begin
            step_cnt <= step_cnt + 1'b1;
          end
        end

        default: state <= sos_pkg::idle;
      endcase
    end
  end

  // the window history starts as all ones so the first two windows can't
  // pass the test on their own
  always_ff @(posedge clk_in) begin
    if (state == sos_pkg::emitting && done) begin
      prev_sum      <= '1;
      prev_prev_sum <= '1;
    end else if (state == sos_pkg::listening && window_done && !echo) begin
      prev_prev_sum <= prev_sum;
      prev_sum      <= window_sum;
    end
  end

  // a result only appears as listening hands back to idle and covers whole windows
  a_valid_on_echo : assert property (
    @(posedge clk_in) disable iff (rst_in)
    $rose(delay_valid) |-> ($past(state) == sos_pkg::listening)
                           && (state == sos_pkg::idle)
                           && (delay % window_size == 0)
  ) else $error("delay_valid rose outside a completed measurement or off a window edge");

endmodule

`default_nettype wire

// ==== source/sos_pkg.sv ====
`default_nettype none

// widths, state encoding and click level shared by the rangefinder blocks
package sos_pkg;

  // microphone sample, two's complement from the codec
  localparam int sample_w = 8;

  // speaker drive word, two's complement
  localparam int amp_w = 16;

  // window sum width; a full-scale sample adds at most 128, so 2**24 samples fit
  localparam int energy_w = 32;

  // click peak, well below full scale to keep the speaker out of clipping
  localparam logic signed [amp_w-1:0] click_amp = 16'sd12000;

  // measurement states as seen on current_state
  typedef enum logic [2:0] {
    idle      = 3'd1, // waiting for a trigger
    emitting  = 3'd2, // click being played
    listening = 3'd3  // summing windows, looking for the echo onset
  } ranger_state_t;

endpackage

`default_nettype wire

// ==== source/sos_ranger_top.sv ====
`default_nettype none

module sos_ranger_top #(
  parameter int clk_div     = 4,   // system clocks per audio sample
  parameter int window_size = 16,  // samples per energy window
  parameter int max_delay   = 256, // listening limit in samples
  parameter int click_len   = 8    // click length in samples
) (
  input  wire                                     clk_in,
  input  wire                                     rst_in,
  input  wire                                     trigger,
  input  wire signed [sos_pkg::sample_w-1:0]      mic_in,
  output logic signed [sos_pkg::amp_w-1:0]        amp_out,
  output logic                                    sample_strobe, // paces the codec
  output logic [$clog2(max_delay + 1)-1:0]        delay,
  output logic                                    delay_valid,
  output sos_pkg::ranger_state_t                  current_state
);

  logic                           clear;
  logic [sos_pkg::energy_w-1:0]   window_sum;
  logic                           window_done;

  sample_strobe_gen #(
    .clk_div (clk_div)
  ) sample_strobe_gen_i (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .step   (sample_strobe)
  );

  sos_dist_calculator #(
    .max_delay   (max_delay),
    .window_size (window_size),
    .click_len   (click_len)
  ) sos_dist_calculator_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .step          (sample_strobe),
    .trigger       (trigger),
    .window_sum    (window_sum),
    .window_done   (window_done),
    .clear         (clear),
    .amp_out       (amp_out),
    .delay         (delay),
    .delay_valid   (delay_valid),
    .current_state (current_state)
  );

  window_energy #(
    .window_size (window_size)
  ) window_energy_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .step        (sample_strobe),
    .clear       (clear),
    .mic_in      (mic_in),
    .window_sum  (window_sum),
    .window_done (window_done)
  );

endmodule

`default_nettype wire

// ==== source/window_energy.sv ====
`default_nettype none

module window_energy #(
  parameter int window_size = 16 // samples per energy window
) (
  input  wire                                   clk_in,
  input  wire                                   rst_in,
  input  wire                                   step,
  input  wire                                   clear,
  input  wire signed [sos_pkg::sample_w-1:0]    mic_in,
  output logic [sos_pkg::energy_w-1:0]          window_sum,
  output logic                                  window_done
);

  localparam int idx_w = (window_size > 1) ? $clog2(window_size) : 1;

  logic [idx_w-1:0]               idx; // position inside the current window
  logic [sos_pkg::energy_w-1:0]   acc;
  logic [sos_pkg::sample_w-1:0]   mag;
  logic [sos_pkg::energy_w-1:0]   acc_next;

  // magnitude as unsigned, so -128 becomes 128 without overflow
  assign mag = mic_in[sos_pkg::sample_w-1] ? sos_pkg::sample_w'(-mic_in)
                                           : sos_pkg::sample_w'(mic_in);

  assign acc_next = acc + sos_pkg::energy_w'(mag);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      idx         <= '0;
      acc         <= '0;
      window_done <= 1'b0;
    end else begin
      window_done <= 1'b0;
      if (clear) begin // realign windows to the start of listening
        idx <= '0;
        acc <= '0;
      end else if (step) begin
        if (idx == idx_w'(window_size - 1)) begin
          idx         <= '0;
          acc         <= '0;
          window_done <= 1'b1;
        end else begin
          idx <= idx + 1'b1;
          acc <= acc_next;
        end
      end
    end
  end

  // finished sum, held until the next window closes
  always_ff @(posedge clk_in) begin
    if (!clear && step && (idx == idx_w'(window_size - 1))) begin
      window_sum <= acc_next;
    end
  end

  // the controller tests each window exactly once
  a_done_pulse : assert property (
    @(posedge clk_in) disable iff (rst_in)
    (window_size > 1) && window_done |=> !window_done
  ) else $error("window_done longer than one cycle");

endmodule

`default_nettype wire
